// ==== build.f ====
src/intraGeomPkg.sv
src/sampleTypesPkg.sv
src/bypassControl.sv
src/edgeSelect.sv
src/edgeDelayLine.sv
src/borderSampleRegs.sv
src/intraBypass.sv
verification/intraBypassTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= intraBypassTb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/intraBypassTb.sv ====
`timescale 1ns/10ps
module intraBypassTb;
	import intraGeomPkg::*;
	import sampleTypesPkg::*;

	localparam int periodNs = 4;
	localparam int resetCycles = 4;
	localparam int idleCycles = 8;
	localparam int stepCycles = 300;
	localparam int steppedTests = 6;
	localparam int drainCycles = 2; // last block still has to leave the delay line
	localparam int testTail = drainCycles + 1;
	localparam int totalCycles = resetCycles + idleCycles + testTail +
		steppedTests * (stepCycles + testTail);
	localparam int timeoutNs = totalCycles * periodNs + 400; // margin for the summary

	// stimulus modes
	localparam int modeMixed = 0;
	localparam int modeTu4 = 1;
	localparam int modeTu8 = 2;
	localparam int modeLast = 3;
	localparam int modeBusy = 4;
	localparam int modeBorder = 5;
	localparam int modeIdle = 6;

	// edge choice in the reference model
	localparam int pickNone = 0;
	localparam int pickRow = 1;
	localparam int pickCol = 2;

	logic clk;
	logic arst_n;
	logic stall;
	logic nStall;
	blockWord_t recSamples;
	logic [2:0] tuSize;
	logic [1:0] partIdx;
	logic [2:0] blkX;
	logic [2:0] blkY;
	logic [coordWidth-1:0] xTb;
	logic [coordWidth-1:0] yTb;
	logic [coordWidth-1:0] nxtXTb;
	logic [coordWidth-1:0] nxtYTb;
	logic [2:0] nxtTuSize;
	logic isCalStage;
	logic isLtBorder;

	edgeWord_t dutBypass1;
	edgeWord_t dutBypass3;
	logic [tagWidth-1:0] dutTag1;
	logic [tagWidth-1:0] dutTag3;
	sample_t dutCorner;
	sample_t dutLeft;
	sample_t dutTop;

	logic refNextRight;
	int refSel1;
	int refSel3;
	edgeWord_t refBypass1;
	edgeWord_t refMid; // bypass three, first stage
	edgeWord_t refBypass3;
	logic [tagWidth-1:0] refTag1;
	logic [tagWidth-1:0] refMidTag;
	logic [tagWidth-1:0] refTag3;
	sample_t refCorner;
	sample_t refLeft;
	sample_t refTop;

	int errCount = 0;
	int passCount = 0;
	int failCount = 0;

	intraBypass UUT (
		.clk(clk), .arst_n(arst_n), .stall(stall), .nStall(nStall),
		.recSamples(recSamples), .tuSize(tuSize), .partIdx(partIdx),
		.blkX(blkX), .blkY(blkY), .xTb(xTb), .yTb(yTb),
		.nxtXTb(nxtXTb), .nxtYTb(nxtYTb), .nxtTuSize(nxtTuSize),
		.isCalStage(isCalStage), .isLtBorder(isLtBorder),
		.bypass1(dutBypass1), .tag1(dutTag1), .bypass3(dutBypass3), .tag3(dutTag3),
		.corner(dutCorner), .leftSample(dutLeft), .topSample(dutTop)
	);

	// first z-order index other than 3, from the next TU's level upwards
	function automatic logic decideNextRight(
		input logic [coordWidth-1:0] x,
		input logic [coordWidth-1:0] y,
		input logic [2:0] size
	);
		logic [1:0] quad;
		if (size != tuSize4 && size != tuSize8)
			return 1'b0;
		for (int lvl = int'(size); lvl <= 5; lvl++) begin
			quad = {y[lvl], x[lvl]};
			if (quad != 2'd3)
				return quad == 2'd1;
		end
		return 1'b0;
	endfunction

	function automatic edgeWord_t extractEdge(input blockWord_t blk, input int pick);
		edgeWord_t e;
		for (int k = 0; k < 4; k++) begin
			if (pick == pickRow)
				e[k] = blk.flat[12 + k];
			else if (pick == pickCol)
				e[k] = blk.flat[4 * k + 3];
			else
				e[k] = '0;
		end
		return e;
	endfunction

	function automatic logic [tagWidth-1:0] makeTagRef(
		input int pick,
		input logic [coordWidth-1:0] x,
		input logic [coordWidth-1:0] y
	);
		logic [posWidth-1:0] xi;
		logic [posWidth-1:0] yi;
		xi = posWidth'((int'(x) % 64) / 4);
		yi = posWidth'((int'(y) % 64) / 4);
		if (pick == pickRow)
			return {1'b0, xi};
		if (pick == pickCol)
			return {1'b1, yi};
		return {1'b0, noEdgePos};
	endfunction

	function automatic bit spansTu(input logic [2:0] idx, input logic [2:0] size);
		return (int'(idx) + 1) * 4 == (1 << int'(size));
	endfunction

	always_comb begin
		refSel1 = pickNone;
		refSel3 = pickNone;
		if (tuSize == tuSize4) begin
			if (partIdx == 2'd1) begin
				refSel1 = pickRow;
				refSel3 = pickRow;
			end else if (partIdx == 2'd3) begin
				refSel1 = refNextRight ? pickRow : pickCol;
				refSel3 = refSel1;
			end else begin
				refSel1 = pickCol;
				refSel3 = pickRow;
			end
		end else if (tuSize == tuSize8) begin
			if (blkX[0] && !blkY[0]) begin
				refSel1 = pickCol;
				refSel3 = pickCol;
			end else if (!blkX[0] && blkY[0]) begin
				refSel1 = pickRow;
				refSel3 = pickRow;
			end else if (blkX[0] && blkY[0]) begin
				refSel3 = refNextRight ? pickRow : pickCol; // bypass one stays empty
			end
		end
	end

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			refNextRight <= 1'b0;
			refBypass1 <= '0;
			refTag1 <= '0;
			refMid <= '0;
			refMidTag <= '0;
			refBypass3 <= '0;
			refTag3 <= '0;
			refCorner <= '0;
			refLeft <= '0;
			refTop <= '0;
		end else begin
			if (!nStall)
				refNextRight <= decideNextRight(nxtXTb, nxtYTb, nxtTuSize);
			if (!stall) begin
				refBypass1 <= extractEdge(recSamples, refSel1);
				refTag1 <= makeTagRef(refSel1, xTb, yTb);
				refMid <= extractEdge(recSamples, refSel3);
				refMidTag <= makeTagRef(refSel3, xTb, yTb);
				refBypass3 <= refMid;
				refTag3 <= refMidTag;
				if (isCalStage) begin
					if (blkX == blkY && spansTu(blkX, tuSize))
						refCorner <= recSamples.flat[15];
					if (isLtBorder && blkX == 3'd0 && spansTu(blkY, tuSize))
						refLeft <= recSamples.flat[12];
					if (yTb % 13'd64 == 13'd0 && blkY == 3'd0 && spansTu(blkX, tuSize))
						refTop <= recSamples.flat[3];
				end
			end
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n) dutBypass1 == refBypass1)
		else begin
			errCount++;
			$display("[ERROR] bypass1: got %h, expected %h",
				$sampled(dutBypass1), $sampled(refBypass1));
		end
	assert property (@(posedge clk) disable iff (!arst_n) dutTag1 == refTag1)
		else begin
			errCount++;
			$display("[ERROR] tag1: got %h, expected %h",
				$sampled(dutTag1), $sampled(refTag1));
		end
	assert property (@(posedge clk) disable iff (!arst_n) dutBypass3 == refBypass3)
		else begin
			errCount++;
			$display("[ERROR] bypass3: got %h, expected %h",
				$sampled(dutBypass3), $sampled(refBypass3));
		end
	assert property (@(posedge clk) disable iff (!arst_n) dutTag3 == refTag3)
		else begin
			errCount++;
			$display("[ERROR] tag3: got %h, expected %h",
				$sampled(dutTag3), $sampled(refTag3));
		end
	assert property (@(posedge clk) disable iff (!arst_n) dutCorner == refCorner)
		else begin
			errCount++;
			$display("[ERROR] corner: got %h, expected %h",
				$sampled(dutCorner), $sampled(refCorner));
		end
	assert property (@(posedge clk) disable iff (!arst_n) dutLeft == refLeft)
		else begin
			errCount++;
			$display("[ERROR] leftSample: got %h, expected %h",
				$sampled(dutLeft), $sampled(refLeft));
		end
	assert property (@(posedge clk) disable iff (!arst_n) dutTop == refTop)
		else begin
			errCount++;
			$display("[ERROR] topSample: got %h, expected %h",
				$sampled(dutTop), $sampled(refTop));
		end
	assert property (@(posedge clk) $rose(arst_n) |-> (dutBypass1 == '0 && dutTag1 == '0 &&
			dutBypass3 == '0 && dutTag3 == '0 && dutCorner == '0 && dutLeft == '0 && dutTop == '0))
		else begin
			errCount++;
			$display("outputs were not all zero when reset was released");
		end
	assert property (@(posedge clk) disable iff (!arst_n)
			stall |=> ($stable(dutCorner) && $stable(dutLeft) && $stable(dutTop)))
		else begin
			errCount++;
			$display("border samples changed while stall was high");
		end

	initial begin
		clk = 1'b0;
		forever #(periodNs / 2) clk = ~clk;
	end

	initial begin
		#(timeoutNs);
		$display("watchdog expired before the tests finished");
		$display("Simulation finished: FAIL");
		$finish;
	end

	task automatic applyStep(input int mode);
		blockWord_t blk;
		logic [2:0] size;
		@(posedge clk);
		for (int i = 0; i < 16; i++)
			blk.flat[i] = sample_t'($urandom);
		if (mode == modeTu4)
			size = tuSize4;
		else if (mode == modeTu8)
			size = tuSize8;
		else if (mode == modeLast || $urandom % 4 != 0)
			size = ($urandom % 2 == 0) ? tuSize4 : tuSize8;
		else
			size = 3'($urandom % 8); // mostly sizes without an edge
		recSamples <= blk;
		tuSize <= size;
		partIdx <= (mode == modeLast) ? 2'd3 : 2'($urandom % 4);
		if (size == tuSize8 && mode == modeLast) begin
			blkX <= 3'd1;
			blkY <= 3'd1;
		end else if (size == tuSize8) begin
			blkX <= 3'($urandom % 2);
			blkY <= 3'($urandom % 2);
		end else if (size == tuSize4) begin
			blkX <= 3'd0;
			blkY <= 3'd0;
		end else begin
			blkX <= 3'($urandom % 8);
			blkY <= 3'($urandom % 8);
		end
		xTb <= coordWidth'($urandom);
		if (mode == modeBorder || $urandom % 4 == 0)
			yTb <= coordWidth'(($urandom % 128) * 64); // top row of a CTU
		else
			yTb <= coordWidth'($urandom);
		nxtXTb <= coordWidth'($urandom);
		nxtYTb <= coordWidth'($urandom);
		if ($urandom % 8 == 0)
			nxtTuSize <= 3'($urandom % 8);
		else
			nxtTuSize <= ($urandom % 2 == 0) ? tuSize4 : tuSize8;
		nStall <= ($urandom % 4 == 0);
		isCalStage <= (mode == modeBorder) ? 1'b1 : ($urandom % 4 != 0);
		isLtBorder <= (mode == modeBorder) ? ($urandom % 4 != 0) : 1'($urandom % 2);
		if (mode == modeIdle)
			stall <= 1'b1;
		else if (mode == modeBusy)
			stall <= ($urandom % 2 == 0);
		else
			stall <= ($urandom % 4 == 0);
	endtask

	task automatic runTest(input string name, input int mode, input int cycles);
		int startErrs;
		startErrs = errCount;
		for (int i = 0; i < cycles; i++)
			applyStep(mode);
		repeat (drainCycles) @(posedge clk); // last block reaches bypass three
		@(negedge clk); // checks of the last edge have reported
		if (errCount == startErrs) begin
			passCount++;
			$display("test %0s: ok", name);
		end else begin
			failCount++;
			$display("test %0s: %0d mismatches", name, errCount - startErrs);
		end
	endtask

	initial begin
		void'($urandom(32'hbb34d24b));
		arst_n = 1'b0;
		stall = 1'b1;
		nStall = 1'b1;
		recSamples = '0;
		tuSize = 3'd0;
		partIdx = 2'd0;
		blkX = 3'd0;
		blkY = 3'd0;
		xTb = '0;
		yTb = '0;
		nxtXTb = '0;
		nxtYTb = '0;
		nxtTuSize = 3'd0;
		isCalStage = 1'b0;
		isLtBorder = 1'b0;
		repeat (resetCycles) @(posedge clk);
		arst_n <= 1'b1;
		runTest("idle after reset", modeIdle, idleCycles);
		runTest("4x4 partitions", modeTu4, stepCycles);
		runTest("8x8 quadrants", modeTu8, stepCycles);
		runTest("last quadrant decision", modeLast, stepCycles);
		runTest("heavy stall", modeBusy, stepCycles);
		runTest("border capture", modeBorder, stepCycles);
		runTest("mixed sizes", modeMixed, stepCycles);
		$display("tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0 && errCount == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== src/intraBypass.sv ====
`timescale 1ns/10ps
module intraBypass (
	input logic clk,
	input logic arst_n,
	input logic stall,
	input logic nStall,
	input sampleTypesPkg::blockWord_t recSamples,
	input logic [2:0] tuSize,
	input logic [1:0] partIdx,
	input logic [2:0] blkX,
	input logic [2:0] blkY,
	input logic [intraGeomPkg::coordWidth-1:0] xTb,
	input logic [intraGeomPkg::coordWidth-1:0] yTb,
	input logic [intraGeomPkg::coordWidth-1:0] nxtXTb,
	input logic [intraGeomPkg::coordWidth-1:0] nxtYTb,
	input logic [2:0] nxtTuSize,
	input logic isCalStage,
	input logic isLtBorder,
	output sampleTypesPkg::edgeWord_t bypass1,
	output logic [intraGeomPkg::tagWidth-1:0] tag1,
	output sampleTypesPkg::edgeWord_t bypass3,
	output logic [intraGeomPkg::tagWidth-1:0] tag3,
	output sampleTypesPkg::sample_t corner,
	output sampleTypesPkg::sample_t leftSample,
	output sampleTypesPkg::sample_t topSample
);
	import intraGeomPkg::*;
	import sampleTypesPkg::*;

	logic [1:0] sel1;
	logic [1:0] sel3;
	logic [tagWidth-1:0] tag1Next;
	logic [tagWidth-1:0] tag3Next;
	logic [tagWidth-1:0] tag3Cand;
	edgeWord_t edge3Cand; // bypass three before the delay line

	bypassControl ctrl (
		.clk(clk), .arst_n(arst_n), .stall(stall), .nStall(nStall),
		.tuSize(tuSize), .partIdx(partIdx), .blkX(blkX), .blkY(blkY),
		.xTb(xTb), .yTb(yTb), .nxtXTb(nxtXTb), .nxtYTb(nxtYTb), .nxtTuSize(nxtTuSize),
		.sel1(sel1), .sel3(sel3), .tag1Next(tag1Next), .tag3Next(tag3Next)
	);

	edgeSelect edgeSel (
		.clk(clk), .arst_n(arst_n), .stall(stall), .recSamples(recSamples),
		.sel1(sel1), .sel3(sel3), .tag1Next(tag1Next), .tag3Next(tag3Next),
		.bypass1(bypass1), .tag1(tag1), .edge3Next(edge3Cand), .tag3Out(tag3Cand)
	);

	edgeDelayLine delay3 (
		.clk(clk), .arst_n(arst_n), .stall(stall),
		.edge3In(edge3Cand), .tag3In(tag3Cand),
		.bypass3(bypass3), .tag3(tag3)
	);

	borderSampleRegs border (
		.clk(clk), .arst_n(arst_n), .stall(stall), .isCalStage(isCalStage),
		.recSamples(recSamples), .tuSize(tuSize), .blkX(blkX), .blkY(blkY),
		.yTb(yTb), .isLtBorder(isLtBorder),
		.corner(corner), .leftSample(leftSample), .topSample(topSample)
	);

endmodule

// ==== src/borderSampleRegs.sv ====
`timescale 1ns/10ps
module borderSampleRegs (
	input logic clk,
	input logic arst_n,
	input logic stall,
	input logic isCalStage,
	input sampleTypesPkg::blockWord_t recSamples,
	input logic [2:0] tuSize,
	input logic [2:0] blkX,
	input logic [2:0] blkY,
	input logic [intraGeomPkg::coordWidth-1:0] yTb,
	input logic isLtBorder,
	output sampleTypesPkg::sample_t corner,
	output sampleTypesPkg::sample_t leftSample,
	output sampleTypesPkg::sample_t topSample
);
	import intraGeomPkg::*;

	logic [6:0] tuDim; // TU size in samples
	logic [6:0] xSpan;
	logic [6:0] ySpan;
	logic lastCol;
	logic lastRow;
	logic cornerHit;
	logic leftHit;
	logic topHit;
	logic capture;

	assign tuDim = 7'd1 << tuSize;
	assign xSpan = ({4'd0, blkX} + 7'd1) << 2;
	assign ySpan = ({4'd0, blkY} + 7'd1) << 2;
	assign lastCol = (xSpan == tuDim);
	assign lastRow = (ySpan == tuDim);

	assign cornerHit = lastCol && (blkX == blkY); // last 4x4 of the TU
	assign leftHit = isLtBorder && (blkX == 3'd0) && lastRow;
	assign topHit = (yTb[ctuLog2-1:0] == '0) && (blkY == 3'd0) && lastCol; // CTU top row

	assign capture = !stall && isCalStage;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			corner <= '0;
			leftSample <= '0;
			topSample <= '0;
		end else if (capture) begin
			if (cornerHit)
				corner <= recSamples.rows[3][3];
			if (leftHit)
				leftSample <= recSamples.rows[3][0];
			if (topHit)
				topSample <= recSamples.rows[0][3];
		end
	end

endmodule

// ==== src/edgeDelayLine.sv ====
`timescale 1ns/10ps
module edgeDelayLine (
	input logic clk,
	input logic arst_n,
	input logic stall,
	input sampleTypesPkg::edgeWord_t edge3In,
	input logic [intraGeomPkg::tagWidth-1:0] tag3In,
	output sampleTypesPkg::edgeWord_t bypass3,
	output logic [intraGeomPkg::tagWidth-1:0] tag3
);
	import intraGeomPkg::*;
	import sampleTypesPkg::*;

	edgeWord_t midEdge; // first stage, block just accepted
	logic [tagWidth-1:0] midTag;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			midEdge <= '0;
			midTag <= '0;
			bypass3 <= '0;
			tag3 <= '0;
		end else if (!stall) begin
			midEdge <= edge3In;
			midTag <= tag3In;
			bypass3 <= midEdge; // previous block moves out
			tag3 <= midTag;
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		stall |=> ($stable(bypass3) && $stable(tag3)));

endmodule

// ==== src/edgeSelect.sv ====
`timescale 1ns/10ps
module edgeSelect (
	input logic clk,
	input logic arst_n,
	input logic stall,
	input sampleTypesPkg::blockWord_t recSamples,
	input logic [1:0] sel1,
	input logic [1:0] sel3,
	input logic [intraGeomPkg::tagWidth-1:0] tag1Next,
	input logic [intraGeomPkg::tagWidth-1:0] tag3Next,
	output sampleTypesPkg::edgeWord_t bypass1,
	output logic [intraGeomPkg::tagWidth-1:0] tag1,
	output sampleTypesPkg::edgeWord_t edge3Next,
	output logic [intraGeomPkg::tagWidth-1:0] tag3Out
);
	import intraGeomPkg::*;
	import sampleTypesPkg::*;

	function automatic edgeWord_t pickEdge(
		input blockWord_t blk,
		input logic [1:0] sel
	);
		edgeWord_t e;
		for (int k = 0; k < 4; k++) begin
			case (sel)
				selBottom: e[k] = blk.rows[3][k]; // bottom row
				selRight: e[k] = blk.rows[k][3]; // right column
				default: e[k] = '0;
			endcase
		end
		return e;
	endfunction

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bypass1 <= '0;
			tag1 <= '0;
		end else if (!stall) begin
			bypass1 <= pickEdge(recSamples, sel1);
			tag1 <= tag1Next;
		end
	end

	// bypass three candidate goes straight into the delay line
	assign edge3Next = pickEdge(recSamples, sel3);
	assign tag3Out = tag3Next;

	assert property (@(posedge clk) disable iff (!arst_n)
		stall |=> ($stable(bypass1) && $stable(tag1)));

endmodule

// ==== src/bypassControl.sv ====
`timescale 1ns/10ps
module bypassControl (
	input logic clk,
	input logic arst_n,
	input logic stall,
	input logic nStall,
	input logic [2:0] tuSize,
	input logic [1:0] partIdx,
	input logic [2:0] blkX,
	input logic [2:0] blkY,
	input logic [intraGeomPkg::coordWidth-1:0] xTb,
	input logic [intraGeomPkg::coordWidth-1:0] yTb,
	input logic [intraGeomPkg::coordWidth-1:0] nxtXTb,
	input logic [intraGeomPkg::coordWidth-1:0] nxtYTb,
	input logic [2:0] nxtTuSize,
	output logic [1:0] sel1,
	output logic [1:0] sel3,
	output logic [intraGeomPkg::tagWidth-1:0] tag1Next,
	output logic [intraGeomPkg::tagWidth-1:0] tag3Next
);
	import intraGeomPkg::*;

	logic nxtRightComb;
	logic nxtFound;
	logic nextIsRight; // registered decision for the current TU
	logic [1:0] lastSel; // edge of a last-quadrant block
	logic [posWidth-1:0] xIdx;
	logic [posWidth-1:0] yIdx;

	function automatic logic [tagWidth-1:0] makeTag(
		input logic [1:0] sel,
		input logic [posWidth-1:0] xPos,
		input logic [posWidth-1:0] yPos
	);
		case (sel)
			selBottom: makeTag = {1'b0, xPos};
			selRight: makeTag = {1'b1, yPos};
			default: makeTag = {1'b0, noEdgePos};
		endcase
	endfunction

	// walk the z-order levels up from the next TU size, first index other than 3 decides
	always_comb begin
		nxtRightComb = 1'b0;
		nxtFound = 1'b0;
		if (nxtTuSize == tuSize4 || nxtTuSize == tuSize8) begin
			for (int lvl = 2; lvl < ctuLog2; lvl++) begin
				if (!nxtFound && lvl >= int'(nxtTuSize) &&
						{nxtYTb[lvl], nxtXTb[lvl]} != 2'b11) begin
					nxtFound = 1'b1;
					nxtRightComb = ({nxtYTb[lvl], nxtXTb[lvl]} == 2'b01);
				end
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			nextIsRight <= 1'b0;
		else if (!nStall)
			nextIsRight <= nxtRightComb;
	end

	assign lastSel = nextIsRight ? selBottom : selRight;
	assign xIdx = posWidth'(xTb[ctuLog2-1:2]); // 4x4 column inside the CTU
	assign yIdx = posWidth'(yTb[ctuLog2-1:2]);

	always_comb begin
		sel1 = selNone;
		sel3 = selNone;
		if (tuSize == tuSize4) begin
			case (partIdx)
				2'd1: begin
					sel1 = selBottom;
					sel3 = selBottom;
				end
				2'd3: begin
					sel1 = lastSel;
					sel3 = lastSel;
				end
				default: begin // partitions 0 and 2
					sel1 = selRight;
					sel3 = selBottom;
				end
			endcase
		end else if (tuSize == tuSize8) begin
			case ({blkX[0], blkY[0]})
				2'b10: begin
					sel1 = selRight;
					sel3 = selRight;
				end
				2'b01: begin
					sel1 = selBottom;
					sel3 = selBottom;
				end
				2'b11: sel3 = lastSel;
				default: ;
			endcase
		end
	end

	assign tag1Next = makeTag(sel1, xIdx, yIdx);
	assign tag3Next = makeTag(sel3, xIdx, yIdx);

	// the prediction stage treats pos 16 as the only no-edge marker
	assert property (@(posedge clk) disable iff (!arst_n)
		(!stall && sel1 == selNone) |-> tag1Next == {1'b0, noEdgePos});
	assert property (@(posedge clk) disable iff (!arst_n)
		(!stall && sel3 == selNone) |-> tag3Next == {1'b0, noEdgePos});

endmodule

// ==== src/sampleTypesPkg.sv ====
package sampleTypesPkg;

	localparam int bitDepth = 8;

	typedef logic [bitDepth-1:0] sample_t;

	// one 4x4 block of reconstructed samples; row 0 and sample 0 sit in the top bits
	typedef union packed {
		sample_t [0:3][0:3] rows; // rows[r][c]
		sample_t [0:15] flat; // raster order, flat[4*r+c]
	} blockWord_t;

	// k runs along the edge, left to right or top to bottom
	typedef sample_t [0:3] edgeWord_t;

endpackage

// ==== src/intraGeomPkg.sv ====
package intraGeomPkg;

	// CTU is fixed at 64x64
	localparam int ctuLog2 = 6;

	// log2 codes of the TU sizes that carry an edge
	localparam logic [2:0] tuSize4 = 3'd2;
	localparam logic [2:0] tuSize8 = 3'd3;

	localparam int posWidth = 5; // 4x4 index inside the CTU, plus the no-edge code
	localparam int coordWidth = 13; // picture coordinates
	localparam int tagWidth = posWidth + 1; // {column flag, pos}

	localparam logic [posWidth-1:0] noEdgePos = 5'd16; // tag pos with no edge behind it

	// edge selects from the controller to the sample mux
	localparam logic [1:0] selNone = 2'd0;
	localparam logic [1:0] selBottom = 2'd1;
	localparam logic [1:0] selRight = 2'd2;

endpackage
